/* bpPkg.sv */
package bpPkg;

    // A fetch line is 16 bytes, so it holds eight halfword slots
    localparam int fetchOffBits = 3;
    localparam int lineSlots = 1 << fetchOffBits;

    // Slot of a halfword within a fetch line
    typedef logic [fetchOffBits-1:0] FetchOff_t;

    // Halfword program counter made of byte address bits 31 to 1
    typedef logic [30:0] Pc_t;

    // BTB update from the backend
    typedef struct packed {
        logic valid;
        logic clean;
        logic multiple;
        FetchOff_t multipleOffs;
        FetchOff_t fetchStartOffs;
        logic [31:0] src;
        logic [31:0] dst;
        logic isJump;
        logic isCall;
        logic compressed;
    } BtUpdate_t;

    // Direction training for the bimodal table
    typedef struct packed {
        logic valid;
        Pc_t pc;
        logic taken;
    } DirUpdate_t;

    // BTB lookup result that is all zero when nothing was found
    typedef struct packed {
        logic found;
        Pc_t dst;
        FetchOff_t srcOffs;
        logic isJump;
        logic isCall;
        logic compr;
        logic multiple;
    } Prediction_t;

    typedef struct packed {
        Pc_t pc;
        logic taken;
        Prediction_t pred;
        Pc_t nextPc;
    } FetchPacket_t;

endpackage

/* branchTargetBuffer.sv */
`timescale 1ns/10ps

module branchTargetBuffer import bpPkg::*; #(
    parameter int numBtbEntries = 32,
    parameter int btbTagBits = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        pcValid,
    input  Pc_t         pc,
    input  BtUpdate_t   btUpdate,
    output Prediction_t prediction
);

    localparam int idxBits = $clog2(numBtbEntries);

    typedef logic [idxBits-1:0] BtbIdx_t;
    typedef logic [btbTagBits-1:0] BtbTag_t;

    // Payload of one entry whose valid bit lives in a separate vector
    typedef struct packed {
        logic isJump;
        logic isCall;
        logic compr;
        Pc_t dst;
        BtbTag_t tag;
        FetchOff_t offs;
    } BtbEntry_t;

    // Contents of the read register
    typedef struct packed {
        BtbEntry_t entry;
        logic multiple;
        Pc_t pc;
    } BtbRead_t;

    // Multiple-flag write waiting for a cycle without an update
    typedef struct packed {
        logic valid;
        BtbIdx_t idx;
    } PendMult_t;

    BtbEntry_t entries [numBtbEntries];
    logic multFlags [numBtbEntries];
    logic [numBtbEntries-1:0] entryValid;

    BtbRead_t fetched;
    logic readValid;
    PendMult_t pendMult;

    BtbIdx_t lookupIdx;
    BtbIdx_t updIdx;
    BtbIdx_t wrIdx;
    BtbEntry_t newEntry;
    logic doWrite;
    logic doClean;
    logic lookupHit;

    // The start slot sits in the low index bits, so each start offset has its own entry
    assign lookupIdx = pc[idxBits-1:0];

    always_ff @(posedge clk) begin
        if (pcValid) begin
            fetched.entry <= entries[lookupIdx];
            fetched.multiple <= multFlags[lookupIdx];
            fetched.pc <= pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            readValid <= 1'b0;
        end else if (pcValid) begin
            readValid <= entryValid[lookupIdx];
        end
    end

    // Tag and offset check on the registered read data
    always_comb begin
        lookupHit = readValid
            && fetched.entry.tag == fetched.pc[idxBits +: btbTagBits]
            // A branch before the start slot was already passed by this fetch
            && fetched.entry.offs >= fetched.pc[fetchOffBits-1:0];

        prediction = '0;
        if (lookupHit) begin
            prediction.found = 1'b1;
            prediction.dst = fetched.entry.dst;
            prediction.srcOffs = fetched.entry.offs;
            prediction.isJump = fetched.entry.isJump;
            prediction.isCall = fetched.entry.isCall;
            prediction.compr = fetched.entry.compr;
            prediction.multiple = fetched.multiple;
        end
    end

    // Update decode
    always_comb begin
        updIdx = {btUpdate.src[idxBits:fetchOffBits+1], btUpdate.fetchStartOffs};

        // The later branch of a line goes into the slot after the earlier one
        wrIdx = updIdx;
        if (btUpdate.multiple) begin
            wrIdx[fetchOffBits-1:0] = btUpdate.multipleOffs;
        end

        doWrite = btUpdate.valid && !btUpdate.clean;
        doClean = btUpdate.valid && btUpdate.clean;

        newEntry.isJump = btUpdate.isJump;
        newEntry.isCall = btUpdate.isCall;
        newEntry.compr = btUpdate.compressed;
        newEntry.dst = btUpdate.dst[31:1];
        newEntry.tag = btUpdate.src[idxBits+1 +: btbTagBits];
        newEntry.offs = btUpdate.src[1 +: fetchOffBits];
    end

    // Entry and flag arrays with one write port each
    always_ff @(posedge clk) begin
        if (doWrite) begin
            entries[wrIdx] <= newEntry;
            multFlags[wrIdx] <= 1'b0;
        end else if (!btUpdate.valid && pendMult.valid) begin
            // The earlier branch now ends its fetch packet when not taken
            multFlags[pendMult.idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
            pendMult <= '0;
        end else if (doClean) begin
            entryValid[updIdx] <= 1'b0;
        end else if (doWrite) begin
            entryValid[wrIdx] <= 1'b1;
            if (btUpdate.multiple) begin
                pendMult <= '{valid: 1'b1, idx: updIdx};
            end
        end else if (pendMult.valid) begin
            // Flag write lands this cycle
            pendMult.valid <= 1'b0;
        end
    end

endmodule

/* bimodalPredictor.sv */
`timescale 1ns/10ps

module bimodalPredictor import bpPkg::*; #(
    parameter int numCounters = 64
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       pcValid,
    input  Pc_t        pc,
    input  DirUpdate_t dirUpdate,
    output logic       predTaken
);

    localparam int ctrIdxBits = $clog2(numCounters);

    typedef logic [1:0] Ctr_t;
    typedef logic [ctrIdxBits-1:0] CtrIdx_t;

    localparam Ctr_t weakNotTaken = 2'b01;
    localparam Ctr_t strongTaken = 2'b11;
    localparam Ctr_t strongNotTaken = 2'b00;

    Ctr_t counters [numCounters];
    Ctr_t readCtr;

    CtrIdx_t lookupIdx;
    CtrIdx_t trainIdx;
    Ctr_t trainCtr;

    assign lookupIdx = pc[ctrIdxBits-1:0];
    assign trainIdx = dirUpdate.pc[ctrIdxBits-1:0];
    assign trainCtr = counters[trainIdx];

    // Registered read that lines up with the BTB read register
    always_ff @(posedge clk) begin
        if (pcValid) begin
            readCtr <= counters[lookupIdx];
        end
    end

    // MSB of a two-bit counter is the taken prediction
    assign predTaken = readCtr[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numCounters; i++) begin
                counters[i] <= weakNotTaken;
            end
        end else if (dirUpdate.valid) begin
            if (dirUpdate.taken) begin
                if (trainCtr != strongTaken) begin
                    counters[trainIdx] <= trainCtr + Ctr_t'(1);
                end
            end else begin
                if (trainCtr != strongNotTaken) begin
                    counters[trainIdx] <= trainCtr - Ctr_t'(1);
                end
            end
        end
    end

endmodule

/* fetchPcGen.sv */
`timescale 1ns/10ps

module fetchPcGen import bpPkg::*; #(
    parameter Pc_t resetPc = '0
) (
    input  logic         clk,
    input  logic         rst,
    input  Prediction_t  prediction,
    input  logic         predTaken,
    input  logic         redirectValid,
    input  Pc_t          redirectPc,
    output logic         pcValid,
    output Pc_t          issuePc,
    output logic         fetchValid,
    output FetchPacket_t packet
);

    // PC issued last cycle, whose lookup results arrive now
    Pc_t lastPc;
    // Set once a PC has been issued after reset
    logic lastValid;

    Pc_t lineBase;
    Pc_t nextPc;
    logic taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            lastValid <= 1'b0;
        end else begin
            lastValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        lastPc <= issuePc;
    end

    assign lineBase = {lastPc[$bits(Pc_t)-1:fetchOffBits], {fetchOffBits{1'b0}}};

    // Direction and next fetch start
    always_comb begin
        taken = prediction.found && (prediction.isJump || predTaken);

        if (redirectValid) begin
            nextPc = redirectPc;
        end else if (taken) begin
            nextPc = prediction.dst;
        end else if (prediction.found && prediction.multiple) begin
            // Another branch follows in this line, so stop right after this one
            nextPc = lineBase + Pc_t'(prediction.srcOffs) + Pc_t'(1);
        end else begin
            nextPc = lineBase + Pc_t'(lineSlots);
        end
    end

    // The very first fetch after reset starts at resetPc
    assign issuePc = (lastValid || redirectValid) ? nextPc : resetPc;

    // Fetching begins right after reset and never stalls
    assign pcValid = !rst;

    // A redirect squashes the packet of this cycle
    assign fetchValid = lastValid && !redirectValid;

    always_comb begin
        packet.pc = lastPc;
        packet.taken = taken;
        packet.pred = prediction;
        packet.nextPc = nextPc;
    end

endmodule

/* branchPredictor.sv */
`timescale 1ns/10ps

module branchPredictor import bpPkg::*; #(
    parameter int numBtbEntries = 32,
    parameter int btbTagBits = 8,
    parameter int numCounters = 64,
    parameter Pc_t resetPc = 31'h0000_4000
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         redirectValid,
    input  Pc_t          redirectPc,
    input  BtUpdate_t    btUpdate,
    input  DirUpdate_t   dirUpdate,
    output logic         fetchValid,
    output FetchPacket_t packet
);

    // Fetch start issued to both tables
    logic pcValid;
    Pc_t issuePc;

    // Lookup results, one cycle after the issue
    Prediction_t prediction;
    logic predTaken;

    fetchPcGen #(
        .resetPc(resetPc)
    ) fetchPcGen_inst (
        .clk(clk),
        .rst(rst),
        .prediction(prediction),
        .predTaken(predTaken),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc),
        .pcValid(pcValid),
        .issuePc(issuePc),
        .fetchValid(fetchValid),
        .packet(packet)
    );

    branchTargetBuffer #(
        .numBtbEntries(numBtbEntries),
        .btbTagBits(btbTagBits)
    ) branchTargetBuffer_inst (
        .clk(clk),
        .rst(rst),
        .pcValid(pcValid),
        .pc(issuePc),
        .btUpdate(btUpdate),
        .prediction(prediction)
    );

    bimodalPredictor #(
        .numCounters(numCounters)
    ) bimodalPredictor_inst (
        .clk(clk),
        .rst(rst),
        .pcValid(pcValid),
        .pc(issuePc),
        .dirUpdate(dirUpdate),
        .predTaken(predTaken)
    );

endmodule

/* branchPredictorAssert.sv */
`timescale 1ns/10ps

module branchPredictorAssert import bpPkg::*; (
    input logic         clk,
    input logic         rst,
    input logic         redirectValid,
    input Pc_t          redirectPc,
    input logic         pcValid,
    input Pc_t          issuePc,
    input logic         fetchValid,
    input FetchPacket_t packet
);

    // Number of protocol violations seen so far
    int unsigned failCount = 0;

    // The first lookup after reset is still in the read register and has no packet yet
    resetNoFetch: assert property (@(posedge clk) rst |=> !fetchValid)
        else begin
            failCount++;
            $error("fetchValid high during or right after reset");
        end

    packetKnown: assert property (@(posedge clk) disable iff (rst)
        fetchValid |-> !$isunknown(packet))
        else begin
            failCount++;
            $error("Valid fetch packet holds unknown bits");
        end

    issueKnown: assert property (@(posedge clk) disable iff (rst)
        pcValid |-> !$isunknown(issuePc))
        else begin
            failCount++;
            $error("Issued fetch PC holds unknown bits");
        end

    // Back-to-back packets form one continuous fetch stream
    pcChain: assert property (@(posedge clk) disable iff (rst)
        fetchValid |=> !fetchValid || packet.pc == $past(packet.nextPc))
        else begin
            failCount++;
            $error("Packet pc does not follow the previous nextPc");
        end

    redirectSquash: assert property (@(posedge clk) disable iff (rst)
        redirectValid |-> !fetchValid)
        else begin
            failCount++;
            $error("Packet left valid in a redirect cycle");
        end

    redirectTarget: assert property (@(posedge clk) disable iff (rst)
        redirectValid |=> redirectValid || (fetchValid && packet.pc == $past(redirectPc)))
        else begin
            failCount++;
            $error("Packet after a redirect does not start there");
        end

endmodule

bind branchPredictor branchPredictorAssert protocolChecks (
    .clk(clk),
    .rst(rst),
    .redirectValid(redirectValid),
    .redirectPc(redirectPc),
    .pcValid(pcValid),
    .issuePc(issuePc),
    .fetchValid(fetchValid),
    .packet(packet)
);

/* branchPredictorTb.sv */
`timescale 1ns/10ps

module branchPredictorTb import bpPkg::*;;

    localparam int clkPeriod = 20;
    localparam int btbEntries = 32;
    localparam int btbIdxBits = 5;
    localparam int tagBits = 8;
    localparam int numCounters = 64;
    localparam int ctrIdxBits = 6;
    localparam Pc_t resetPc = 31'h0000_4000;
    // Cycles taken by the scripted stimulus including reset
    localparam int scriptCycles = 45;
    localparam int marginCycles = 40;

    typedef struct packed {
        logic valid;
        logic [tagBits-1:0] tag;
        Prediction_t pred;
    } ModelEntry_t;

    logic clk;
    logic rst;
    logic redirectValid;
    Pc_t redirectPc;
    BtUpdate_t btUpdate;
    DirUpdate_t dirUpdate;
    logic fetchValid;
    FetchPacket_t packet;

    // Shadow model of both tables and of the issue stage
    ModelEntry_t mBtb [btbEntries];
    logic [1:0] mCtr [numCounters];
    logic mPendValid;
    logic [btbIdxBits-1:0] mPendIdx;
    Prediction_t mPred;
    logic mCtrMsb;
    Pc_t mLastPc;
    logic mLastValid;

    Pc_t expLineBase;
    Pc_t expNextPc;
    Pc_t expIssuePc;
    logic expTaken;
    logic expFetchValid;

    logic [31:0] rngState = 32'd50436;
    int jumpsSeen = 0;
    int condTakenSeen = 0;
    int condNotTakenSeen = 0;
    int multSeen = 0;

    branchPredictor branchPredictor_inst (
        .clk(clk),
        .rst(rst),
        .redirectValid(redirectValid),
        .redirectPc(redirectPc),
        .btUpdate(btUpdate),
        .dirUpdate(dirUpdate),
        .fetchValid(fetchValid),
        .packet(packet)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic abortRun(string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic reportMismatch(string name, logic [63:0] got, logic [63:0] expected);
        abortRun($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, expected));
    endtask

    function automatic logic [31:0] randomWord();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    // Line start whose low line bits keep the scenarios apart in both tables
    function automatic Pc_t pickLine(logic [2:0] lineLow);
        logic [31:0] r;
        r = randomWord();
        return {r[24:0], lineLow, 3'b000};
    endfunction

    function automatic BtUpdate_t makeUpdate(Pc_t branchPc, FetchOff_t startOffs, Pc_t target,
                                             logic jump);
        BtUpdate_t u;
        u = '0;
        u.valid = 1'b1;
        u.fetchStartOffs = startOffs;
        u.src = {branchPc, 1'b0};
        u.dst = {target, 1'b0};
        u.isJump = jump;
        u.compressed = branchPc[0];
        return u;
    endfunction

    function automatic Prediction_t lookupModel(Pc_t pc);
        ModelEntry_t e;
        e = mBtb[pc[btbIdxBits-1:0]];
        if (e.valid && e.tag == pc[btbIdxBits +: tagBits]
                && e.pred.srcOffs >= pc[fetchOffBits-1:0]) begin
            return e.pred;
        end
        return '0;
    endfunction

    always_comb begin
        expLineBase = mLastPc & ~Pc_t'(lineSlots - 1);
        expTaken = mPred.found && (mPred.isJump || mCtrMsb);
        if (redirectValid) begin
            expNextPc = redirectPc;
        end else if (expTaken) begin
            expNextPc = mPred.dst;
        end else if (mPred.found && mPred.multiple) begin
            expNextPc = expLineBase + Pc_t'(mPred.srcOffs) + Pc_t'(1);
        end else begin
            expNextPc = expLineBase + Pc_t'(lineSlots);
        end
        expIssuePc = (mLastValid || redirectValid) ? expNextPc : resetPc;
        expFetchValid = mLastValid && !redirectValid;
    end

    always @(posedge clk) begin : shadowModel
        Pc_t srcPc;
        logic [btbIdxBits-1:0] updIdx;
        logic [btbIdxBits-1:0] wrIdx;
        logic [ctrIdxBits-1:0] ctrIdx;
        ModelEntry_t newEntry;
        if (rst) begin
            for (int i = 0; i < btbEntries; i++) begin
                mBtb[i] <= '0;
            end
            for (int i = 0; i < numCounters; i++) begin
                mCtr[i] <= 2'd1;
            end
            mPendValid <= 1'b0;
            mPred <= '0;
            mCtrMsb <= 1'b0;
            mLastPc <= resetPc;
            mLastValid <= 1'b0;
        end else begin
            if (expFetchValid && mPred.found) begin
                jumpsSeen += int'(mPred.isJump);
                condTakenSeen += int'(!mPred.isJump && mCtrMsb);
                condNotTakenSeen += int'(!mPred.isJump && !mCtrMsb);
                multSeen += int'(mPred.multiple);
            end
            mPred <= lookupModel(expIssuePc);
            mCtrMsb <= mCtr[expIssuePc[ctrIdxBits-1:0]][1];
            mLastPc <= expIssuePc;
            mLastValid <= 1'b1;

            srcPc = btUpdate.src[31:1];
            updIdx = {srcPc[btbIdxBits-1:fetchOffBits], btUpdate.fetchStartOffs};
            wrIdx = btUpdate.multiple
                ? {srcPc[btbIdxBits-1:fetchOffBits], btUpdate.multipleOffs} : updIdx;
            newEntry = '0;
            newEntry.valid = 1'b1;
            newEntry.tag = srcPc[btbIdxBits +: tagBits];
            newEntry.pred.found = 1'b1;
            newEntry.pred.dst = btUpdate.dst[31:1];
            newEntry.pred.srcOffs = srcPc[fetchOffBits-1:0];
            newEntry.pred.isJump = btUpdate.isJump;
            newEntry.pred.isCall = btUpdate.isCall;
            newEntry.pred.compr = btUpdate.compressed;
            if (btUpdate.valid && btUpdate.clean) begin
                mBtb[updIdx].valid <= 1'b0;
            end else if (btUpdate.valid) begin
                mBtb[wrIdx] <= newEntry;
                if (btUpdate.multiple) begin
                    mPendValid <= 1'b1;
                    mPendIdx <= updIdx;
                end
            end else if (mPendValid) begin
                mBtb[mPendIdx].pred.multiple <= 1'b1;
                mPendValid <= 1'b0;
            end

            if (dirUpdate.valid) begin
                ctrIdx = dirUpdate.pc[ctrIdxBits-1:0];
                if (dirUpdate.taken && mCtr[ctrIdx] != 2'd3) begin
                    mCtr[ctrIdx] <= mCtr[ctrIdx] + 2'd1;
                end else if (!dirUpdate.taken && mCtr[ctrIdx] != 2'd0) begin
                    mCtr[ctrIdx] <= mCtr[ctrIdx] - 2'd1;
                end
            end
        end
    end

    fetchValidCheck: assert property (@(posedge clk) disable iff (rst)
        fetchValid == expFetchValid)
        else reportMismatch("fetchValid", $sampled(fetchValid), $sampled(expFetchValid));
    pcCheck: assert property (@(posedge clk) disable iff (rst)
        fetchValid |-> packet.pc == mLastPc)
        else reportMismatch("packet.pc", $sampled(packet.pc), $sampled(mLastPc));
    predCheck: assert property (@(posedge clk) disable iff (rst)
        fetchValid |-> packet.pred == mPred)
        else reportMismatch("packet.pred", $sampled(packet.pred), $sampled(mPred));
    takenCheck: assert property (@(posedge clk) disable iff (rst)
        fetchValid |-> packet.taken == expTaken)
        else reportMismatch("packet.taken", $sampled(packet.taken), $sampled(expTaken));
    nextPcCheck: assert property (@(posedge clk) disable iff (rst)
        fetchValid |-> packet.nextPc == expNextPc)
        else reportMismatch("packet.nextPc", $sampled(packet.nextPc), $sampled(expNextPc));

    always @(negedge clk) begin
        if (branchPredictor_inst.protocolChecks.failCount != 0) begin
            abortRun("A bound protocol assertion on the DUT failed");
        end
    end

    initial begin
        #((scriptCycles + marginCycles) * clkPeriod);
        abortRun("Timeout, the scripted stimulus did not finish in time");
    end

    task automatic nextCycle();
        @(negedge clk);
        btUpdate = '0;
        dirUpdate = '0;
        redirectValid = 1'b0;
    endtask

    task automatic idle(int n);
        repeat (n) nextCycle();
    endtask

    task automatic writeBtb(BtUpdate_t u);
        nextCycle();
        btUpdate = u;
    endtask

    task automatic redirect(Pc_t pc);
        nextCycle();
        redirectValid = 1'b1;
        redirectPc = pc;
    endtask

    task automatic train(Pc_t pc, logic taken);
        nextCycle();
        dirUpdate = '{valid: 1'b1, pc: pc, taken: taken};
    endtask

    initial begin : stimulus
        string problem;
        Pc_t jumpLine;
        Pc_t jumpDst;
        Pc_t condLine;
        Pc_t multLine;
        BtUpdate_t upd;
        rst = 1'b1;
        redirectValid = 1'b0;
        redirectPc = '0;
        btUpdate = '0;
        dirUpdate = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        // Empty tables give a plain sequential stream from resetPc
        idle(6);

        // Unconditional jump in slot 4 fetched from its line start
        jumpLine = pickLine(3'd1);
        jumpDst = Pc_t'(randomWord());
        upd = makeUpdate(jumpLine + Pc_t'(4), 3'd0, jumpDst, 1'b1);
        // The jump is a call so that the isCall bit travels through the table
        upd.isCall = 1'b1;
        writeBtb(upd);
        redirect(jumpLine);
        idle(3);

        // Conditional branch that is not taken at first and taken after two trainings
        condLine = pickLine(3'd3);
        writeBtb(makeUpdate(condLine, 3'd0, Pc_t'(randomWord()), 1'b0));
        redirect(condLine);
        idle(2);
        train(condLine, 1'b1);
        train(condLine, 1'b1);
        redirect(condLine);
        idle(3);

        // Entry for a fetch from slot 6 with its branch in slot 4 is filtered out
        writeBtb(makeUpdate(jumpLine + Pc_t'(4), 3'd6, jumpDst, 1'b1));
        redirect(jumpLine + Pc_t'(6));
        idle(2);
        upd = makeUpdate(jumpLine + Pc_t'(4), 3'd0, jumpDst, 1'b1);
        upd.clean = 1'b1;
        writeBtb(upd);
        redirect(jumpLine);
        idle(2);

        // Earlier branch in slot 2 and later jump in slot 5 stored at slot 3
        multLine = pickLine(3'd6);
        writeBtb(makeUpdate(multLine + Pc_t'(2), 3'd0, Pc_t'(randomWord()), 1'b0));
        upd = makeUpdate(multLine + Pc_t'(5), 3'd0, Pc_t'(randomWord()), 1'b1);
        upd.multiple = 1'b1;
        upd.multipleOffs = 3'd3;
        writeBtb(upd);
        idle(1);
        redirect(multLine);
        idle(3);

        // Redirect into the middle of the running stream
        redirect(Pc_t'(randomWord()));
        idle(3);
        idle(2);

        problem = "";
        if (branchPredictor_inst.protocolChecks.failCount != 0) begin
            problem = "A bound protocol assertion on the DUT failed";
        end else if (jumpsSeen == 0 || condTakenSeen == 0 || condNotTakenSeen == 0
                || multSeen == 0) begin
            problem = "A scripted branch scenario never reached a fetch packet";
        end
        if (problem.len() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abortRun(problem);
        end
    end

endmodule

/* sim.f */
bpPkg.sv
branchTargetBuffer.sv
bimodalPredictor.sv
fetchPcGen.sv
branchPredictor.sv
branchPredictorAssert.sv
branchPredictorTb.sv
